// File: rtl/cpu_bus_if.sv
`timescale 1ns/1ps

interface cpu_ibus_if;
	logic        read;
	logic [31:0] address;
	logic [31:0] rddata;
	logic        valid;

	modport master(
		output read, address,
		input  rddata, valid
	);

	modport slave(
		input  read, address,
		output rddata, valid
	);
endinterface

interface cpu_dbus_if;
	logic        read;
	logic        write;
	logic [31:0] address;
	logic [31:0] wrdata;
	logic [31:0] rddata;

	modport master(
		output read, write, address, wrdata,
		input  rddata
	);

	modport slave(
		input  read, write, address, wrdata,
		output rddata
	);
endinterface

// File: rtl/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_core(
	input  logic               clk,
	input  logic               rst,
	cpu_ibus_if.master         ibus,
	cpu_dbus_if.master         dbus,
	output logic               wb_valid,
	output cpu_pkg::reg_addr_t wb_rd,
	output logic [31:0]        wb_data
);

import cpu_pkg::*;

logic [31:0] pc;
logic [31:0] id_pc;
logic        fetch_valid;
logic        id_hold;
logic        id_valid;
logic        stall;
logic        branch_taken;
logic [31:0] branch_target;

reg_addr_t [1:0]  reg_raddr;
logic [1:0][31:0] reg_rdata;

pipeline_decode_t pipe_decode;
pipeline_decode_t pipe_decode_d;
pipeline_exec_t   pipe_exec;
pipeline_exec_t   pipe_exec_d;
pipeline_memwb_t  pipe_mem_d;
pipeline_memwb_t  pipe_wb;
logic             wb_is_load;

// no fetch while decode is held, and none down a taken branch's fall-through
assign ibus.read    = fetch_valid & ~stall & ~branch_taken;
assign ibus.address = pc;

always_ff @(posedge clk) begin
	if (rst) begin
		pc          <= `RESET_PC;
		fetch_valid <= 1'b0;
	end else begin
		fetch_valid <= 1'b1;
		if (branch_taken)
			pc <= branch_target;
		else if (ibus.read)
			pc <= pc + 32'd4;
	end
end

always_ff @(posedge clk) begin
	if (rst)
		id_hold <= 1'b0;
	else
		id_hold <= stall;
end

always_ff @(posedge clk) begin
	if (ibus.read)
		id_pc <= pc;
end

// memory keeps the word on its port while no new read is issued
assign id_valid = ibus.valid | id_hold;

regfile regfile_inst(
	.clk,
	.rst,
	.raddr ( reg_raddr     ),
	.rdata ( reg_rdata     ),
	.we    ( pipe_wb.valid ),
	.waddr ( pipe_wb.rd    ),
	.wdata ( pipe_wb.wdata )
);

decode decode_inst(
	.instr      ( ibus.rddata           ),
	.pc         ( id_pc                 ),
	.valid      ( id_valid              ),
	.reg_raddr,
	.reg_rdata,
	.ex_is_load ( pipe_decode_d.is_load ),
	.ex_rd      ( pipe_decode_d.rd      ),
	.result     ( pipe_decode           ),
	.stall_req  ( stall                 )
);

// a stall sends a bubble into execute
always_ff @(posedge clk) begin
	if (rst || stall)
		pipe_decode_d <= '0;
	else
		pipe_decode_d <= pipe_decode;
end

instr_exec exec_inst(
	.data    ( pipe_decode_d ),
	.mem_fwd ( pipe_exec_d   ),
	.wb_fwd  ( pipe_wb       ),
	.result  ( pipe_exec     ),
	.branch_taken,
	.branch_target
);

always_ff @(posedge clk) begin
	if (rst)
		pipe_exec_d <= '0;
	else
		pipe_exec_d <= pipe_exec;
end

assign dbus.read    = pipe_exec_d.valid & pipe_exec_d.is_load;
assign dbus.write   = pipe_exec_d.valid & pipe_exec_d.is_store;
assign dbus.address = pipe_exec_d.result;
assign dbus.wrdata  = pipe_exec_d.store_data;

always_ff @(posedge clk) begin
	if (rst) begin
		pipe_mem_d <= '0;
		wb_is_load <= 1'b0;
	end else begin
		pipe_mem_d.valid <= pipe_exec_d.valid;
		pipe_mem_d.rd    <= pipe_exec_d.rd;
		pipe_mem_d.wdata <= pipe_exec_d.result;
		wb_is_load       <= dbus.read;
	end
end

// load data arrives from the bus in this cycle
always_comb begin
	pipe_wb = pipe_mem_d;
	if (wb_is_load)
		pipe_wb.wdata = dbus.rddata;
end

assign wb_valid = pipe_wb.valid && pipe_wb.rd != '0;
assign wb_rd    = pipe_wb.rd;
assign wb_data  = pipe_wb.wdata;

endmodule

// File: rtl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// architectural registers, r0 included
`define REG_NUM 32

// unified memory, counted in 32-bit words
`define MEM_WORDS 1024

// word index width into the unified memory
`define MEM_ADDR_W 10

// byte address of the first fetch
`define RESET_PC 32'h0000_0000

`endif

// File: rtl/cpu_pkg.sv
package cpu_pkg;

typedef logic [4:0] reg_addr_t;

typedef struct packed {
	logic [5:0] opcode;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;
	logic [4:0] shamt;
	logic [5:0] funct;
} instr_r_t;

typedef struct packed {
	logic [5:0]  opcode;
	reg_addr_t   rs;
	reg_addr_t   rt;
	logic [15:0] imm;
} instr_i_t;

// same word, register or immediate layout
typedef union packed {
	instr_r_t r;
	instr_i_t i;
} instr_t;

typedef enum logic [2:0] {
	ALU_ADD,
	ALU_SUB,
	ALU_AND,
	ALU_OR,
	ALU_XOR,
	ALU_SLT,
	ALU_LUI,
	ALU_PASS
} alu_op_t;

typedef struct packed {
	logic        valid;
	logic [31:0] pc;
	reg_addr_t   rs;
	reg_addr_t   rt;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] imm;
	alu_op_t     alu_op;
	logic        use_imm;
	logic        is_load;
	logic        is_store;
	logic        is_branch;
	logic        branch_ne;
	// zero when nothing is written back
	reg_addr_t   rd;
} pipeline_decode_t;

typedef struct packed {
	logic        valid;
	logic [31:0] result;
	logic [31:0] store_data;
	logic        is_load;
	logic        is_store;
	reg_addr_t   rd;
} pipeline_exec_t;

typedef struct packed {
	logic        valid;
	reg_addr_t   rd;
	logic [31:0] wdata;
} pipeline_memwb_t;

endpackage

// File: rtl/decode.sv
`timescale 1ns/1ps

module decode(
	input  cpu_pkg::instr_t           instr,
	input  logic [31:0]               pc,
	input  logic                      valid,
	output cpu_pkg::reg_addr_t [1:0]  reg_raddr,
	input  logic [1:0][31:0]          reg_rdata,
	input  logic                      ex_is_load,
	input  cpu_pkg::reg_addr_t        ex_rd,
	output cpu_pkg::pipeline_decode_t result,
	output logic                      stall_req
);

import cpu_pkg::*;

localparam logic [5:0] OP_SPECIAL = 6'h00;
localparam logic [5:0] OP_BEQ     = 6'h04;
localparam logic [5:0] OP_BNE     = 6'h05;
localparam logic [5:0] OP_ADDIU   = 6'h09;
localparam logic [5:0] OP_ORI     = 6'h0d;
localparam logic [5:0] OP_LUI     = 6'h0f;
localparam logic [5:0] OP_LW      = 6'h23;
localparam logic [5:0] OP_SW      = 6'h2b;

localparam logic [5:0] FN_ADDU = 6'h21;
localparam logic [5:0] FN_SUBU = 6'h23;
localparam logic [5:0] FN_AND  = 6'h24;
localparam logic [5:0] FN_OR   = 6'h25;
localparam logic [5:0] FN_XOR  = 6'h26;
localparam logic [5:0] FN_SLT  = 6'h2a;

logic        use_rs;
logic        use_rt;
logic [31:0] imm_sext;
logic [31:0] imm_zext;

assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
assign imm_zext = {16'b0, instr.i.imm};

assign reg_raddr[0] = instr.i.rs;
assign reg_raddr[1] = instr.i.rt;

always_comb begin
	result         = '0;
	use_rs         = 1'b0;
	use_rt         = 1'b0;
	result.valid   = valid;
	result.pc      = pc;
	result.rs      = instr.i.rs;
	result.rt      = instr.i.rt;
	result.rs_data = reg_rdata[0];
	result.rt_data = reg_rdata[1];
	result.imm     = imm_sext;
	result.alu_op  = ALU_PASS;
	case (instr.i.opcode)
		OP_SPECIAL: begin
			use_rs    = 1'b1;
			use_rt    = 1'b1;
			result.rd = instr.r.rd;
			case (instr.r.funct)
				FN_ADDU: result.alu_op = ALU_ADD;
				FN_SUBU: result.alu_op = ALU_SUB;
				FN_AND:  result.alu_op = ALU_AND;
				FN_OR:   result.alu_op = ALU_OR;
				FN_XOR:  result.alu_op = ALU_XOR;
				FN_SLT:  result.alu_op = ALU_SLT;
				// unsupported funct behaves as a nop
				default: result.rd = '0;
			endcase
		end
		OP_ADDIU, OP_ORI, OP_LW: begin
			use_rs         = 1'b1;
			result.use_imm = 1'b1;
			result.rd      = instr.i.rt;
			result.is_load = instr.i.opcode == OP_LW;
			result.alu_op  = instr.i.opcode == OP_ORI ? ALU_OR : ALU_ADD;
			if (instr.i.opcode == OP_ORI)
				result.imm = imm_zext;
		end
		OP_LUI: begin
			result.use_imm = 1'b1;
			result.imm     = imm_zext;
			result.rd      = instr.i.rt;
			result.alu_op  = ALU_LUI;
		end
		OP_SW: begin
			use_rs          = 1'b1;
			use_rt          = 1'b1;
			result.use_imm  = 1'b1;
			result.is_store = 1'b1;
			result.alu_op   = ALU_ADD;
		end
		OP_BEQ, OP_BNE: begin
			use_rs           = 1'b1;
			use_rt           = 1'b1;
			result.is_branch = 1'b1;
			result.branch_ne = instr.i.opcode == OP_BNE;
		end
		default: ;
	endcase
	if (!valid)
		result = '0;
end

// load in execute feeding this instruction
assign stall_req = valid && ex_is_load && ex_rd != '0
	&& ((use_rs && ex_rd == instr.i.rs) || (use_rt && ex_rd == instr.i.rt));

endmodule

// File: rtl/instr_exec.sv
`timescale 1ns/1ps

module instr_exec(
	input  cpu_pkg::pipeline_decode_t data,
	input  cpu_pkg::pipeline_exec_t   mem_fwd,
	input  cpu_pkg::pipeline_memwb_t  wb_fwd,
	output cpu_pkg::pipeline_exec_t   result,
	output logic                      branch_taken,
	output logic [31:0]               branch_target
);

import cpu_pkg::*;

logic [31:0] op_rs;
logic [31:0] op_rt;
logic [31:0] op_b;

// memory stage is younger, so it wins over write-back
function automatic logic [31:0] fwd(
	input reg_addr_t       idx,
	input logic [31:0]     value,
	input pipeline_exec_t  mem,
	input pipeline_memwb_t wb
);
	if (mem.valid && mem.rd != '0 && mem.rd == idx)
		return mem.result;
	if (wb.valid && wb.rd != '0 && wb.rd == idx)
		return wb.wdata;
	return value;
endfunction

assign op_rs = fwd(data.rs, data.rs_data, mem_fwd, wb_fwd);
assign op_rt = fwd(data.rt, data.rt_data, mem_fwd, wb_fwd);
assign op_b  = data.use_imm ? data.imm : op_rt;

always_comb begin
	result            = '0;
	result.valid      = data.valid;
	result.store_data = op_rt;
	result.is_load    = data.is_load;
	result.is_store   = data.is_store;
	result.rd         = data.rd;
	case (data.alu_op)
		ALU_ADD: result.result = op_rs + op_b;
		ALU_SUB: result.result = op_rs - op_b;
		ALU_AND: result.result = op_rs & op_b;
		ALU_OR:  result.result = op_rs | op_b;
		ALU_XOR: result.result = op_rs ^ op_b;
		ALU_SLT: result.result = {31'b0, $signed(op_rs) < $signed(op_b)};
		ALU_LUI: result.result = {op_b[15:0], 16'b0};
		default: result.result = op_b;
	endcase
end

// target is relative to the delay slot
assign branch_target = data.pc + 32'd4 + {data.imm[29:0], 2'b00};
assign branch_taken  = data.valid && data.is_branch
	&& ((op_rs == op_rt) != data.branch_ne);

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regfile(
	input  logic                     clk,
	input  logic                     rst,
	input  cpu_pkg::reg_addr_t [1:0] raddr,
	output logic [1:0][31:0]         rdata,
	input  logic                     we,
	input  cpu_pkg::reg_addr_t       waddr,
	input  logic [31:0]              wdata
);

logic [31:0] regs [`REG_NUM];

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `REG_NUM; i++)
			regs[i] <= '0;
	end else if (we && waddr != '0) begin
		regs[waddr] <= wdata;
	end
end

// same-cycle write is visible to the reader
always_comb begin
	for (int p = 0; p < 2; p++) begin
		if (raddr[p] == '0)
			rdata[p] = '0;
		else if (we && waddr == raddr[p])
			rdata[p] = wdata;
		else
			rdata[p] = regs[raddr[p]];
	end
end

endmodule

// File: rtl/soc_top.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module soc_top(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   prog_we,
	input  logic [`MEM_ADDR_W-1:0] prog_addr,
	input  logic [31:0]            prog_data,
	output logic                   wb_valid,
	output logic [4:0]             wb_rd,
	output logic [31:0]            wb_data
);

cpu_ibus_if ibus();
cpu_dbus_if dbus();

cpu_core cpu_core_inst(
	.clk,
	.rst,
	.ibus     ( ibus     ),
	.dbus     ( dbus     ),
	.wb_valid,
	.wb_rd,
	.wb_data
);

// program load shares the memory with both core buses
unified_mem unified_mem_inst(
	.clk,
	.ibus      ( ibus      ),
	.dbus      ( dbus      ),
	.prog_we,
	.prog_addr,
	.prog_data
);

endmodule

// File: rtl/unified_mem.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module unified_mem(
	input  logic                   clk,
	cpu_ibus_if.slave              ibus,
	cpu_dbus_if.slave              dbus,
	input  logic                   prog_we,
	input  logic [`MEM_ADDR_W-1:0] prog_addr,
	input  logic [31:0]            prog_data
);

logic [31:0]            mem [`MEM_WORDS];
logic [`MEM_ADDR_W-1:0] iaddr;
logic [`MEM_ADDR_W-1:0] daddr;

// byte addresses from the core, word index here
assign iaddr = ibus.address[`MEM_ADDR_W+1:2];
assign daddr = dbus.address[`MEM_ADDR_W+1:2];

always_ff @(posedge clk) begin
	if (prog_we)
		mem[prog_addr] <= prog_data;
	else if (dbus.write)
		mem[daddr] <= dbus.wrdata;
end

// last fetched word stays put between reads
always_ff @(posedge clk) begin
	ibus.valid <= ibus.read;
	if (ibus.read)
		ibus.rddata <= mem[iaddr];
end

always_ff @(posedge clk) begin
	if (dbus.read)
		dbus.rddata <= mem[daddr];
end

endmodule

// File: run.sh
#!/bin/sh
# builds and runs tb_soc with Verilator, exits nonzero unless the pass line is in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module tb_soc --Mdir obj_dir

status=0
./obj_dir/Vtb_soc > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Done: no errors" sim.log; then
	echo "simulation passed (exit status $status)"
	exit 0
else
	echo "simulation failed (exit status $status)"
	exit 1
fi

// File: src.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_bus_if.sv
rtl/regfile.sv
rtl/decode.sv
rtl/instr_exec.sv
rtl/cpu_core.sv
rtl/unified_mem.sv
rtl/soc_top.sv
verification/tb_soc.sv

// File: verification/tb_soc.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_soc;

localparam logic [5:0] OP_SPECIAL = 6'h00;
localparam logic [5:0] OP_BEQ     = 6'h04;
localparam logic [5:0] OP_BNE     = 6'h05;
localparam logic [5:0] OP_ADDIU   = 6'h09;
localparam logic [5:0] OP_ORI     = 6'h0d;
localparam logic [5:0] OP_LUI     = 6'h0f;
localparam logic [5:0] OP_LW      = 6'h23;
localparam logic [5:0] OP_SW      = 6'h2b;
localparam logic [5:0] FN_ADDU    = 6'h21;
localparam logic [5:0] FN_SUBU    = 6'h23;
localparam logic [5:0] FN_AND     = 6'h24;
localparam logic [5:0] FN_OR      = 6'h25;
localparam logic [5:0] FN_XOR     = 6'h26;
localparam logic [5:0] FN_SLT     = 6'h2a;
// data words live at byte 0x800, away from the program
localparam int DATA_BASE  = 512;
localparam int DATA_WORDS = 16;

logic                   clk;
logic                   rst;
logic                   prog_we;
logic [`MEM_ADDR_W-1:0] prog_addr;
logic [31:0]            prog_data;
logic                   wb_valid;
logic [4:0]             wb_rd;
logic [31:0]            wb_data;

logic [31:0] rng;
logic [31:0] prog [512];
int          prog_len;
logic [31:0] halt_pc;
logic [31:0] model_mem [`MEM_WORDS];
// expected write-backs as {rd, data}
logic [36:0] exp_q [$];
int          cycles;
int          limit;

soc_top i_soc_top(
	.clk,
	.rst,
	.prog_we,
	.prog_addr,
	.prog_data,
	.wb_valid,
	.wb_rd,
	.wb_data
);

always #2 clk = ~clk;

function logic [31:0] next_rand();
	rng = rng ^ (rng << 13);
	rng = rng ^ (rng >> 17);
	rng = rng ^ (rng << 5);
	return rng;
endfunction

function automatic logic [31:0] fill_word(input logic [`MEM_ADDR_W-1:0] a);
	return 32'h9e37_79b9 * {22'd0, a} + {a, 22'h15_a5a5};
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
	return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function void emit(input logic [31:0] w);
	prog[prog_len] = w;
	prog_len++;
endfunction

// registers r0..r7 only, so dependences come often
function automatic logic [31:0] random_alu(input logic [31:0] r);
	logic [4:0] rd;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [5:0] fn;
	logic [3:0] kind;
	rd   = {2'b00, r[10:8]};
	rs   = {2'b00, r[13:11]};
	rt   = {2'b00, r[16:14]};
	kind = r[3:0] % 4'd9;
	fn   = FN_ADDU;
	case (kind)
		4'd0: fn = FN_ADDU;
		4'd1: fn = FN_SUBU;
		4'd2: fn = FN_AND;
		4'd3: fn = FN_OR;
		4'd4: fn = FN_XOR;
		4'd5: fn = FN_SLT;
		4'd6: return enc_i(OP_ADDIU, rs, rt, r[31:16]);
		4'd7: return enc_i(OP_ORI, rs, rt, r[31:16]);
		default: return enc_i(OP_LUI, 5'd0, rt, r[31:16]);
	endcase
	return enc_r(fn, rs, rt, rd);
endfunction

task automatic build_program();
	logic [31:0] r;
	logic [4:0]  ra;
	logic [4:0]  rb;
	prog_len = 0;
	for (int i = 0; i < 100; i++) begin
		r  = next_rand();
		ra = {2'b00, r[13:11]};
		rb = {2'b00, r[16:14]};
		case (r[31:29])
			3'd0: emit(enc_i(OP_LW, 5'd0, rb, 16'h0800 + {10'd0, r[7:4], 2'b00}));
			3'd1: emit(enc_i(OP_SW, 5'd0, rb, 16'h0800 + {10'd0, r[7:4], 2'b00}));
			3'd2: begin
				emit(enc_i(r[28] ? OP_BNE : OP_BEQ, ra, rb, 16'd1));
				emit(random_alu(next_rand()));
				emit(random_alu(next_rand()));
			end
			default: emit(random_alu(r));
		endcase
	end
	// forwarding at distance 1, 2 and 3
	emit(enc_i(OP_ADDIU, 5'd0, 5'd9, 16'h1234));
	emit(enc_r(FN_ADDU, 5'd9, 5'd9, 5'd10));
	emit(enc_i(OP_ORI, 5'd0, 5'd11, 16'h80f0));
	emit(enc_r(FN_SUBU, 5'd10, 5'd9, 5'd12));
	emit(enc_r(FN_SLT, 5'd12, 5'd11, 5'd13));
	// load-use, then a load consumed two later
	emit(enc_i(OP_LW, 5'd0, 5'd14, 16'h0800));
	emit(enc_r(FN_ADDU, 5'd14, 5'd9, 5'd15));
	emit(enc_i(OP_LW, 5'd0, 5'd16, 16'h0804));
	emit(enc_i(OP_LUI, 5'd0, 5'd17, 16'h8001));
	emit(enc_r(FN_XOR, 5'd16, 5'd17, 5'd18));
	// store then load, same and different word
	emit(enc_i(OP_SW, 5'd0, 5'd12, 16'h0808));
	emit(enc_i(OP_LW, 5'd0, 5'd19, 16'h0808));
	emit(enc_i(OP_LW, 5'd0, 5'd20, 16'h080c));
	emit(enc_i(OP_SW, 5'd0, 5'd15, 16'h0810));
	emit(enc_r(FN_OR, 5'd20, 5'd19, 5'd21));
	emit(enc_i(OP_LW, 5'd0, 5'd21, 16'h0810));
	// beq taken, beq not taken, bne taken, bne not taken
	emit(enc_i(OP_BEQ, 5'd9, 5'd9, 16'd1));
	emit(enc_i(OP_ADDIU, 5'd0, 5'd22, 16'd1));
	emit(enc_i(OP_ADDIU, 5'd0, 5'd22, 16'd2));
	emit(enc_i(OP_ADDIU, 5'd22, 5'd23, 16'h0010));
	emit(enc_i(OP_BEQ, 5'd9, 5'd10, 16'd1));
	emit(enc_i(OP_ADDIU, 5'd0, 5'd22, 16'd3));
	emit(enc_i(OP_ADDIU, 5'd0, 5'd22, 16'd4));
	emit(enc_i(OP_BNE, 5'd9, 5'd10, 16'd1));
	emit(enc_i(OP_ADDIU, 5'd0, 5'd23, 16'd5));
	emit(enc_i(OP_ADDIU, 5'd0, 5'd23, 16'd6));
	emit(enc_i(OP_BNE, 5'd9, 5'd9, 16'd1));
	emit(enc_i(OP_ADDIU, 5'd0, 5'd24, 16'd7));
	emit(enc_i(OP_ADDIU, 5'd0, 5'd24, 16'd8));
	// branch on a value just loaded
	emit(enc_i(OP_LW, 5'd0, 5'd25, 16'h0814));
	emit(enc_i(OP_BEQ, 5'd25, 5'd25, 16'd1));
	emit(enc_r(FN_ADDU, 5'd25, 5'd0, 5'd26));
	emit(enc_i(OP_ADDIU, 5'd0, 5'd26, 16'd9));
	// r0 as a destination, then as a source
	emit(enc_i(OP_ADDIU, 5'd9, 5'd0, 16'h0055));
	emit(enc_r(FN_ADDU, 5'd9, 5'd9, 5'd0));
	emit(enc_r(FN_ADDU, 5'd0, 5'd9, 5'd27));
	emit(enc_r(FN_OR, 5'd0, 5'd0, 5'd28));
	// park the core in a self loop
	halt_pc = prog_len * 4;
	emit(enc_i(OP_BEQ, 5'd0, 5'd0, 16'hffff));
	emit(32'h0000_0000);
endtask

// instruction-level model in program order with one delay slot
task automatic run_model();
	logic [31:0] regs [32];
	logic [31:0] pc;
	logic [31:0] npc;
	logic [31:0] target;
	logic [31:0] w;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] val;
	logic [31:0] addr;
	logic [4:0]  dest;
	logic        taken;
	int          steps;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	for (int i = 0; i < `MEM_WORDS; i++)
		model_mem[i] = (i < prog_len) ? prog[i] : '0;
	for (int k = 0; k < DATA_WORDS; k++)
		model_mem[DATA_BASE + k] = fill_word(10'(DATA_BASE + k));
	pc    = 32'd0;
	npc   = 32'd4;
	steps = 0;
	while (pc != halt_pc && steps < 10000) begin
		w      = model_mem[pc[`MEM_ADDR_W+1:2]];
		a      = regs[w[25:21]];
		b      = regs[w[20:16]];
		simm   = {{16{w[15]}}, w[15:0]};
		addr   = a + simm;
		target = pc + 32'd4 + (simm << 2);
		dest   = '0;
		val    = '0;
		taken  = 1'b0;
		case (w[31:26])
			OP_SPECIAL: begin
				dest = w[15:11];
				case (w[5:0])
					FN_ADDU: val = a + b;
					FN_SUBU: val = a - b;
					FN_AND:  val = a & b;
					FN_OR:   val = a | b;
					FN_XOR:  val = a ^ b;
					FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: dest = '0;
				endcase
			end
			OP_ADDIU: begin
				dest = w[20:16];
				val  = addr;
			end
			OP_ORI: begin
				dest = w[20:16];
				val  = a | {16'd0, w[15:0]};
			end
			OP_LUI: begin
				dest = w[20:16];
				val  = {w[15:0], 16'd0};
			end
			OP_LW: begin
				dest = w[20:16];
				val  = model_mem[addr[`MEM_ADDR_W+1:2]];
			end
			OP_SW: model_mem[addr[`MEM_ADDR_W+1:2]] = b;
			OP_BEQ: taken = (a == b);
			OP_BNE: taken = (a != b);
			default: ;
		endcase
		if (dest != '0) begin
			regs[dest] = val;
			exp_q.push_back({dest, val});
		end
		pc  = npc;
		npc = taken ? target : npc + 32'd4;
		steps++;
	end
endtask

task abort_run(input string msg);
	$display("%s", msg);
	$display("Done: errors found");
	$fatal(1);
endtask

// outputs settle well before the falling edge
always @(negedge clk) begin
	logic [36:0] head;
	if (wb_valid) begin
		assert (exp_q.size() != 0)
			else abort_run($sformatf("unexpected write-back to r%0d at %0t", wb_rd, $time));
		head = exp_q.pop_front();
		assert (wb_rd == head[36:32])
			else abort_run($sformatf("Fail at %0t: wb_rd expected %0d, got %0d",
				$time, head[36:32], wb_rd));
		assert (wb_data == head[31:0])
			else abort_run($sformatf("Fail at %0t: wb_data expected %08h, got %08h (r%0d)",
				$time, head[31:0], wb_data, wb_rd));
	end
end

always @(posedge clk) begin
	if (rst) begin
		cycles <= 0;
	end else begin
		cycles <= cycles + 1;
		if (cycles > limit)
			abort_run("timeout: the core did not retire every expected write-back in time");
	end
end

initial begin
	clk       = 1'b0;
	rst       = 1'b1;
	prog_we   = 1'b0;
	prog_addr = '0;
	prog_data = '0;
	rng       = 32'h454181c6;
	build_program();
	run_model();
	limit = 4 * prog_len + 100;
	// program and data words go in while the core is held in reset
	for (int i = 0; i < prog_len; i++) begin
		@(negedge clk);
		prog_we   = 1'b1;
		prog_addr = i[`MEM_ADDR_W-1:0];
		prog_data = prog[i];
	end
	for (int k = 0; k < DATA_WORDS; k++) begin
		@(negedge clk);
		prog_addr = 10'(DATA_BASE + k);
		prog_data = fill_word(10'(DATA_BASE + k));
	end
	@(negedge clk);
	prog_we = 1'b0;
	repeat (10) @(negedge clk);
	rst = 1'b0;
	while (exp_q.size() != 0)
		@(negedge clk);
	// a few more cycles to catch stray write-backs
	repeat (20) @(negedge clk);
	@(posedge clk);
	$display("Done: no errors");
	$finish;
end

endmodule
